// ==== crc16_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc16_unit import tx_pkg::*; (
	input  logic        core_clk_i,
	input  logic        rst_n_i,
	input  logic        clear_i,
	input  logic        enable_i,
	input  logic [7:0]  data_i,
	output logic [15:0] crc_o
);

	logic [15:0] crc_q;
	logic [15:0] crc_next;

	// Byte folded in MSB first.
	always_comb begin
		logic fb;
		crc_next = crc_q;
		for (int i = 7; i >= 0; i--) begin
			fb = crc_next[15] ^ data_i[i];
			crc_next = {crc_next[14:0], 1'b0} ^ (fb ? CRC_POLY : 16'h0000);
		end
	end

	always_ff @(posedge core_clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			crc_q <= CRC_INIT;
		else if (clear_i)
			crc_q <= CRC_INIT;
		else if (enable_i)
			crc_q <= crc_next;
	end

	assign crc_o = crc_q;

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
tx_pkg.sv
crc16_unit.sv
mailbox_framer.sv
tx_arbiter.sv
tx_core.sv
tb_tx_core.sv

// ==== mailbox_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mailbox_framer import tx_pkg::*; #(
	parameter prio_e PRIO      = LANE_LO,
	parameter int    MAILBOXES = 4
) (
	input  logic                 core_clk_i,
	input  logic                 rst_n_i,
	input  logic [MAILBOXES-1:0] start_i,
	output logic [MAILBOXES-1:0] wip_o,
	output logic                 req_o,
	input  logic                 grant_i,
	output logic                 busy_o,
	output logic [ADDR_W-1:0]    rd_addr_o,
	input  logic [7:0]           rd_data_i,
	output tx_word_t             word_o
);

	framer_state_e        state_q;
	logic [MAILBOXES-1:0] pend_q;
	logic [MAILBOXES-1:0] sel_q;       // One-hot, mailbox being sent.
	logic [MAILBOXES-1:0] end_mask;
	logic [MAILBOXES-1:0] first_mask;
	logic [ADDR_W-1:0]    first_idx;
	logic [ADDR_W-1:0]    first_addr;
	logic [ADDR_W-1:0]    addr_q;
	logic [CNT_W-1:0]     len2_q;      // 2*L.
	logic [CNT_W-1:0]     cnt_q;
	logic [15:0]          crc;

	// ########################################################################
	// Pending flags and mailbox choice.
	// ########################################################################

	assign end_mask = (state_q == ST_END) ? sel_q : '0;
	assign wip_o    = pend_q & ~end_mask;
	assign req_o    = (|pend_q) && (state_q == ST_IDLE);
	assign busy_o   = (state_q != ST_IDLE);

	// Lowest index wins.
	always_comb begin
		first_idx  = '0;
		first_mask = '0;
		for (int i = MAILBOXES - 1; i >= 0; i--) begin
			if (pend_q[i]) begin
				first_idx  = ADDR_W'(i);
				first_mask = '0;
				first_mask[i] = 1'b1;
			end
		end
	end

	assign first_addr = lane_base(PRIO) + ADDR_W'(first_idx * MSG_BYTES);

	// Base address goes out in the grant cycle, so the header arrives in ST_HEADER.
	assign rd_addr_o = grant_i ? first_addr : addr_q;

	// ########################################################################
	// Frame sequence.
	// ########################################################################

	always_ff @(posedge core_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
			pend_q  <= '0;
			addr_q  <= '0;
		end else begin
			pend_q <= wip_o | start_i;
			if (state_q != ST_IDLE)
				addr_q <= addr_q + 1'b1;
			case (state_q)
				ST_IDLE: begin
					if (grant_i) begin
						state_q <= ST_START;
						addr_q  <= first_addr + 1'b1;
					end
				end
				ST_START:  state_q <= ST_HEADER;
				ST_HEADER: state_q <= ST_LENGTH;
				ST_LENGTH: state_q <= (rd_data_i == '0) ? ST_CRC_LO : ST_DATA;
				ST_DATA: begin
					if (cnt_q == len2_q)
						state_q <= ST_CRC_LO;
				end
				ST_CRC_LO: state_q <= ST_CRC_HI;
				ST_CRC_HI: state_q <= ST_END;
				default:   state_q <= ST_IDLE;  // ST_END.
			endcase
		end
	end

	always_ff @(posedge core_clk_i) begin
		if (grant_i)
			sel_q <= first_mask;
		if (state_q == ST_LENGTH) begin
			len2_q <= {rd_data_i[CNT_W-2:0], 1'b0};
			cnt_q  <= CNT_W'(1);
		end else if (state_q == ST_DATA) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	crc16_unit i_crc (
		.core_clk_i (core_clk_i),
		.rst_n_i    (rst_n_i),
		.clear_i    (state_q == ST_START),
		.enable_i   (state_q inside {ST_HEADER, ST_LENGTH, ST_DATA}),
		.data_i     (rd_data_i),
		.crc_o      (crc)
	);

	// ########################################################################
	// Output word.
	// ########################################################################

	always_comb begin
		word_o.write  = (state_q != ST_IDLE);
		word_o.lane   = PRIO;
		case (state_q)
			ST_IDLE:   word_o.symbol = '0;
			ST_START:  word_o.symbol = start_code(PRIO);
			ST_CRC_LO: word_o.symbol = {1'b0, crc[7:0]};
			ST_CRC_HI: word_o.symbol = {1'b0, crc[15:8]};
			ST_END:    word_o.symbol = end_code(PRIO);
			default:   word_o.symbol = {1'b0, rd_data_i};  // Header, length, data.
		endcase
	end

	a_grant_needs_req: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
		grant_i |-> req_o);

	a_length_legal: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
		(state_q == ST_LENGTH) |-> (rd_data_i <= 8'(MAX_LENGTH)));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator, then looks for the pass message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module tb_tx_core -o tb_tx_core || { echo "Build failed"; exit 1; }
sim_out="$(./obj_dir/tb_tx_core 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -q "Simulation passed" && exit 0 || exit 1

// ==== tb_frame_model.svh ====
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// CRC-16, polynomial 0x1021, byte put into the high half and shifted out MSB first.
function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [7:0] data);
	logic [15:0] c;
	c = crc ^ {data, 8'h00};
	for (int b = 0; b < 8; b++) begin
		if (c[15])
			c = {c[14:0], 1'b0} ^ 16'h1021;
		else
			c = {c[14:0], 1'b0};
	end
	return c;
endfunction

function automatic int mailbox_base(input prio_e lane, input int mbox);
	if (lane == LANE_HI)
		return int'(HIPRI_BASE) + mbox * MSG_BYTES;
	return int'(LOPRI_BASE) + mbox * MSG_BYTES;
endfunction

function automatic tx_word_t make_word(input prio_e lane, input logic [8:0] sym);
	tx_word_t w;
	w.write  = 1'b1;
	w.lane   = lane;
	w.symbol = sym;
	return w;
endfunction

// Fills exp_words with the frame that a mailbox should produce.
task automatic build_expected(input prio_e lane, input int mbox);
	int          base;
	int          len;
	logic [15:0] crc;
	base    = mailbox_base(lane, mbox);
	len     = int'(mem[base + 1]);
	exp_len = 2 * len + 6;
	crc     = 16'hFFFF;
	exp_words[0] = make_word(lane, (lane == LANE_HI) ? K_START_HI : K_START_LO);
	for (int i = 0; i < 2 * len + 2; i++) begin  // Header, length and data.
		exp_words[1 + i] = make_word(lane, {1'b0, mem[base + i]});
		crc = crc16_step(crc, mem[base + i]);
	end
	exp_words[2 * len + 3] = make_word(lane, {1'b0, crc[7:0]});
	exp_words[2 * len + 4] = make_word(lane, {1'b0, crc[15:8]});
	exp_words[2 * len + 5] = make_word(lane, (lane == LANE_HI) ? K_END_HI : K_END_LO);
endtask

`endif

// ==== tb_tx_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tx_core import tx_pkg::*; ();

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 8;
	localparam int QUIET_CYCLES = 20;
	localparam int NUM_FRAMES   = 60;
	localparam int WATCHDOG_NS  = (RESET_CYCLES + QUIET_CYCLES
		+ NUM_FRAMES * (2 * MAX_LENGTH + 8) * 2) * CLK_PERIOD;

	logic                       core_clk_i;
	logic                       rst_n_i;
	logic [HIPRI_MAILBOXES-1:0] tx_hipri_start_i;
	logic [HIPRI_MAILBOXES-1:0] tx_hipri_wip_o;
	logic [LOPRI_MAILBOXES-1:0] tx_lopri_start_i;
	logic [LOPRI_MAILBOXES-1:0] tx_lopri_wip_o;
	logic [ADDR_W-1:0]          mem_addr_o;
	logic [7:0]                 mem_data_i;
	tx_word_t                   tx_word_o;

	logic [7:0]                 mem [0:(1 << ADDR_W) - 1];
	logic [ADDR_W-1:0]          last_addr;
	logic [15:0]                lfsr_q;
	tx_word_t                   exp_words [0:2*MAX_LENGTH+5];
	int                         exp_len;
	int                         word_idx;
	logic                       in_frame;
	prio_e                      cur_lane;
	int                         cur_mbox;
	logic [HIPRI_MAILBOXES-1:0] pend_hi;     // Model of the pending flags.
	logic [LOPRI_MAILBOXES-1:0] pend_lo;
	logic [HIPRI_MAILBOXES-1:0] grant_hi;    // Flags as the arbiter saw them last cycle.
	logic [LOPRI_MAILBOXES-1:0] grant_lo;
	logic                       gap_due;
	int                         idle_wait;
	int                         accepted;
	int                         frames_done;

	`include "tb_frame_model.svh"

	tx_core i_dut (
		.core_clk_i       (core_clk_i),
		.rst_n_i          (rst_n_i),
		.tx_hipri_start_i (tx_hipri_start_i),
		.tx_hipri_wip_o   (tx_hipri_wip_o),
		.tx_lopri_start_i (tx_lopri_start_i),
		.tx_lopri_wip_o   (tx_lopri_wip_o),
		.mem_addr_o       (mem_addr_o),
		.mem_data_i       (mem_data_i),
		.tx_word_o        (tx_word_o)
	);

	always #(CLK_PERIOD / 2) core_clk_i = ~core_clk_i;

	// ########################################################################
	// Random source and checks.
	// ########################################################################

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1.
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[14:0], lfsr_q[0]};
		end
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("[FAIL] %0d ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			$display("Simulation failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// Header, then L in 0..7, then data bytes.
	task automatic fill_mailbox(input prio_e lane, input int mbox);
		logic [15:0] r;
		int          base;
		base = mailbox_base(lane, mbox);
		take_bits(8, r);
		mem[base] = r[7:0];
		take_bits(3, r);
		mem[base + 1] = {5'b0, r[2:0]};
		for (int i = 2; i < MSG_BYTES; i++) begin
			take_bits(8, r);
			mem[base + i] = r[7:0];
		end
	endtask

	// ########################################################################
	// Frame tracking.
	// ########################################################################

	task automatic pick_next(output logic found);
		found = 1'b0;
		for (int m = HIPRI_MAILBOXES - 1; m >= 0; m--) begin
			if (grant_hi[m]) begin
				cur_lane = LANE_HI;
				cur_mbox = m;
				found    = 1'b1;
			end
		end
		for (int m = LOPRI_MAILBOXES - 1; m >= 0; m--) begin
			if (!(|grant_hi) && grant_lo[m]) begin
				cur_lane = LANE_LO;
				cur_mbox = m;
				found    = 1'b1;
			end
		end
	endtask

	task automatic track_word(input tx_word_t word);
		logic [HIPRI_MAILBOXES-1:0] hi_before;
		logic [LOPRI_MAILBOXES-1:0] lo_before;
		logic                       found;
		hi_before = pend_hi;
		lo_before = pend_lo;
		if (in_frame) begin
			check_value(32'(word), 32'(exp_words[word_idx]), "frame word mismatch");
			word_idx++;
			idle_wait = 0;
			if (word_idx == exp_len) begin  // End word seen.
				in_frame = 1'b0;
				gap_due  = 1'b1;
				frames_done++;
				if (cur_lane == LANE_HI)
					pend_hi[cur_mbox] = 1'b0;
				else
					pend_lo[cur_mbox] = 1'b0;
			end
		end else if (word.write) begin
			check_value(gap_due, 0, "write in the idle cycle after a frame");
			pick_next(found);
			check_value(found, 1, "frame started with no mailbox pending");
			build_expected(cur_lane, cur_mbox);
			check_value(32'(word), 32'(exp_words[0]), "start word or chosen mailbox wrong");
			word_idx  = 1;
			in_frame  = 1'b1;
			idle_wait = 0;
		end else begin
			gap_due   = 1'b0;
			idle_wait = (|hi_before || |lo_before) ? idle_wait + 1 : 0;
			check_value(idle_wait > 2, 0, "pending mailbox not started in time");
		end
		grant_hi = hi_before;
		grant_lo = lo_before;
	endtask

	// Drives one cycle on the falling edge and samples a quarter period later.
	task automatic run_cycle(input logic strobes_on, input logic quiet);
		logic [HIPRI_MAILBOXES-1:0] hi_strobe;
		logic [LOPRI_MAILBOXES-1:0] lo_strobe;
		logic [HIPRI_MAILBOXES-1:0] hi_new;
		logic [LOPRI_MAILBOXES-1:0] lo_new;
		logic [15:0]                r;
		tx_word_t                   word;
		@(negedge core_clk_i);
		mem_data_i = mem[last_addr];  // One cycle of read latency.
		last_addr  = mem_addr_o;
		hi_strobe  = '0;
		lo_strobe  = '0;
		hi_new     = '0;
		lo_new     = '0;
		if (strobes_on) begin
			for (int m = 0; m < HIPRI_MAILBOXES; m++) begin
				take_bits(7, r);
				hi_strobe[m] = (r[6:0] == 7'd0);
				if (hi_strobe[m] && !tx_hipri_wip_o[m]) begin
					fill_mailbox(LANE_HI, m);
					hi_new[m] = 1'b1;
				end
			end
			for (int m = 0; m < LOPRI_MAILBOXES; m++) begin
				take_bits(6, r);
				lo_strobe[m] = (r[5:0] == 6'd0);
				if (lo_strobe[m] && !tx_lopri_wip_o[m]) begin
					fill_mailbox(LANE_LO, m);
					lo_new[m] = 1'b1;
				end
			end
		end
		tx_hipri_start_i = hi_strobe;
		tx_lopri_start_i = lo_strobe;
		#(CLK_PERIOD / 4);
		word = tx_word_o;
		if (quiet) begin
			check_value(word.write, 0, "write high with no strobes");
			check_value({tx_hipri_wip_o, tx_lopri_wip_o}, 0, "wip high with no strobes");
		end
		track_word(word);
		check_value(tx_hipri_wip_o, pend_hi, "high-priority wip bits");
		check_value(tx_lopri_wip_o, pend_lo, "low-priority wip bits");
		pend_hi  = pend_hi | hi_new;
		pend_lo  = pend_lo | lo_new;
		accepted = accepted + $countones(hi_new) + $countones(lo_new);
	endtask

	// ########################################################################
	// Main sequence and watchdog.
	// ########################################################################

	initial begin
		core_clk_i       = 1'b0;
		rst_n_i          = 1'b0;
		tx_hipri_start_i = '0;
		tx_lopri_start_i = '0;
		mem_data_i       = '0;
		last_addr        = '0;
		lfsr_q           = 16'd45;
		in_frame         = 1'b0;
		gap_due          = 1'b0;
		word_idx         = 0;
		exp_len          = 0;
		cur_lane         = LANE_LO;
		cur_mbox         = 0;
		pend_hi          = '0;
		pend_lo          = '0;
		grant_hi         = '0;
		grant_lo         = '0;
		idle_wait        = 0;
		accepted         = 0;
		frames_done      = 0;
		for (int m = 0; m < LOPRI_MAILBOXES; m++)
			fill_mailbox(LANE_LO, m);
		for (int m = 0; m < HIPRI_MAILBOXES; m++)
			fill_mailbox(LANE_HI, m);
		repeat (RESET_CYCLES) @(posedge core_clk_i);
		@(negedge core_clk_i);
		rst_n_i = 1'b1;
		repeat (QUIET_CYCLES) run_cycle(1'b0, 1'b1);
		while (accepted < NUM_FRAMES)
			run_cycle(1'b1, 1'b0);
		while (in_frame || (|pend_hi) || (|pend_lo))  // Drain.
			run_cycle(1'b0, 1'b0);
		repeat (5) run_cycle(1'b0, 1'b0);
		$display("%0d frames checked", frames_done);
		$display("Simulation passed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns, the frames did not finish", WATCHDOG_NS);
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// ==== tx_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_arbiter import tx_pkg::*; (
	input  logic              core_clk_i,
	input  logic              rst_n_i,
	input  logic              hi_req_i,
	input  logic              lo_req_i,
	input  logic              hi_busy_i,
	input  logic              lo_busy_i,
	output logic              hi_grant_o,
	output logic              lo_grant_o,
	input  logic [ADDR_W-1:0] hi_addr_i,
	input  logic [ADDR_W-1:0] lo_addr_i,
	input  tx_word_t          hi_word_i,
	input  tx_word_t          lo_word_i,
	output logic [ADDR_W-1:0] mem_addr_o,
	output tx_word_t          tx_word_o
);

	logic gap_q;    // Set for the cycle after any busy cycle.
	logic free;
	logic hi_sel;

	assign free       = !hi_busy_i && !lo_busy_i && !gap_q;
	assign hi_grant_o = free && hi_req_i;
	assign lo_grant_o = free && lo_req_i && !hi_req_i;  // High lane first.

	assign hi_sel = hi_busy_i || hi_grant_o;

	always_ff @(posedge core_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			gap_q      <= 1'b0;
			mem_addr_o <= '0;
		end else begin
			gap_q      <= hi_busy_i || lo_busy_i;
			mem_addr_o <= hi_sel ? hi_addr_i : lo_addr_i;
		end
	end

	always_comb begin
		if (hi_busy_i)
			tx_word_o = hi_word_i;
		else if (lo_busy_i)
			tx_word_o = lo_word_i;
		else
			tx_word_o = '{write: 1'b0, lane: LANE_LO, symbol: '0};
	end

	a_one_busy: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
		!(hi_busy_i && lo_busy_i));

	// Only the granted framer is busy on the next cycle.
	a_grant_taken: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
		(hi_grant_o || lo_grant_o) |=>
			(hi_busy_i == $past(hi_grant_o)) && (lo_busy_i == $past(lo_grant_o)));

endmodule

`default_nettype wire

// ==== tx_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_core import tx_pkg::*; (
	input  logic                       core_clk_i,
	input  logic                       rst_n_i,
	input  logic [HIPRI_MAILBOXES-1:0] tx_hipri_start_i,
	output logic [HIPRI_MAILBOXES-1:0] tx_hipri_wip_o,
	input  logic [LOPRI_MAILBOXES-1:0] tx_lopri_start_i,
	output logic [LOPRI_MAILBOXES-1:0] tx_lopri_wip_o,
	output logic [ADDR_W-1:0]          mem_addr_o,
	input  logic [7:0]                 mem_data_i,
	output tx_word_t                   tx_word_o
);

	logic              hi_req, lo_req;
	logic              hi_grant, lo_grant;
	logic              hi_busy, lo_busy;
	logic [ADDR_W-1:0] hi_addr, lo_addr;
	tx_word_t          hi_word, lo_word;

	mailbox_framer #(.PRIO(LANE_HI), .MAILBOXES(HIPRI_MAILBOXES)) hi_framer (
		.core_clk_i (core_clk_i),
		.rst_n_i    (rst_n_i),
		.start_i    (tx_hipri_start_i),
		.wip_o      (tx_hipri_wip_o),
		.req_o      (hi_req),
		.grant_i    (hi_grant),
		.busy_o     (hi_busy),
		.rd_addr_o  (hi_addr),
		.rd_data_i  (mem_data_i),
		.word_o     (hi_word)
	);

	mailbox_framer #(.PRIO(LANE_LO), .MAILBOXES(LOPRI_MAILBOXES)) lo_framer (
		.core_clk_i (core_clk_i),
		.rst_n_i    (rst_n_i),
		.start_i    (tx_lopri_start_i),
		.wip_o      (tx_lopri_wip_o),
		.req_o      (lo_req),
		.grant_i    (lo_grant),
		.busy_o     (lo_busy),
		.rd_addr_o  (lo_addr),
		.rd_data_i  (mem_data_i),
		.word_o     (lo_word)
	);

	tx_arbiter i_arbiter (
		.core_clk_i (core_clk_i),
		.rst_n_i    (rst_n_i),
		.hi_req_i   (hi_req),
		.lo_req_i   (lo_req),
		.hi_busy_i  (hi_busy),
		.lo_busy_i  (lo_busy),
		.hi_grant_o (hi_grant),
		.lo_grant_o (lo_grant),
		.hi_addr_i  (hi_addr),
		.lo_addr_i  (lo_addr),
		.hi_word_i  (hi_word),
		.lo_word_i  (lo_word),
		.mem_addr_o (mem_addr_o),
		.tx_word_o  (tx_word_o)
	);

endmodule

`default_nettype wire

// ==== tx_pkg.sv ====
`default_nettype none

package tx_pkg;

	// ########################################################################
	// Sizes and buffer address map.
	// ########################################################################

	localparam int HIPRI_MAILBOXES = 4;
	localparam int LOPRI_MAILBOXES = 4;
	localparam int MSG_BYTES       = 16;  // Header, length and up to 14 data bytes.
	localparam int MAX_LENGTH      = 7;
	localparam int ADDR_W          = 7;
	localparam int CNT_W           = 4;   // Holds 2*MAX_LENGTH.

	localparam logic [ADDR_W-1:0] LOPRI_BASE = 7'd0;
	localparam logic [ADDR_W-1:0] HIPRI_BASE = 7'd64;

	localparam logic [15:0] CRC_POLY = 16'h1021;
	localparam logic [15:0] CRC_INIT = 16'hFFFF;

	// ########################################################################
	// Types.
	// ########################################################################

	typedef enum logic {
		LANE_LO = 1'b0,
		LANE_HI = 1'b1
	} prio_e;

	// Control words, bit 8 marks a K code.
	typedef enum logic [8:0] {
		K_START_HI = 9'h1FB,
		K_END_HI   = 9'h1FD,
		K_START_LO = 9'h15C,
		K_END_LO   = 9'h1F7
	} code_e;

	typedef enum logic [2:0] {
		ST_IDLE, ST_START, ST_HEADER, ST_LENGTH,
		ST_DATA, ST_CRC_LO, ST_CRC_HI, ST_END
	} framer_state_e;

	typedef struct packed {
		logic        write;   // FIFO write strobe.
		prio_e       lane;    // Selects the lane FIFO.
		logic [8:0]  symbol;
	} tx_word_t;

	function automatic logic [ADDR_W-1:0] lane_base(prio_e lane);
		return (lane == LANE_HI) ? HIPRI_BASE : LOPRI_BASE;
	endfunction

	function automatic code_e start_code(prio_e lane);
		return (lane == LANE_HI) ? K_START_HI : K_START_LO;
	endfunction

	function automatic code_e end_code(prio_e lane);
		return (lane == LANE_HI) ? K_END_HI : K_END_LO;
	endfunction

endpackage

`default_nettype wire
